// ==== hw/isa_pkg.sv ====
package isa_pkg;

	// ------------------------------------------------------------------------
	// Instruction field widths and bit positions
	// ------------------------------------------------------------------------

	localparam int inst_field_width = 26;
	localparam int reg_index_width  = 5;

	// Register numbers sit in the low bits, the 16-bit offset above them
	localparam int inst_rd_lsb     = 0;
	localparam int inst_rj_lsb     = 5;
	localparam int inst_offs16_lsb = 10;

	// Offset split of the 26-bit form, low part stored above the high part
	localparam int offs26_hi_width = 10;

	typedef logic [inst_field_width-1:0] inst_field_t;
	typedef logic [reg_index_width-1:0]  reg_index_t;

	// Return address register by convention
	localparam reg_index_t link_reg_index = 5'd1;

	// ------------------------------------------------------------------------
	// Branch and compare kinds from decode
	// ------------------------------------------------------------------------

	typedef enum logic [1:0] {
		branch_none,
		branch_condition,
		branch_immediate,
		branch_indirect
	} branch_kind_t;

	typedef enum logic [2:0] {
		cmp_eql,
		cmp_neq,
		cmp_lss,
		cmp_ger,
		cmp_leq,
		cmp_geq,
		cmp_ltu,
		cmp_geu
	} cmp_kind_t;

endpackage : isa_pkg

// ==== hw/bp_pkg.sv ====
package bp_pkg;

	// ------------------------------------------------------------------------
	// Address types
	// ------------------------------------------------------------------------

	localparam int addr_width = 32;

	typedef logic [addr_width-1:0] addr_t;

	// Instructions are word aligned, so the two low bits are dropped
	typedef logic [addr_width-3:0] word_addr_t;

	// ------------------------------------------------------------------------
	// Direction counters and branch classes
	// ------------------------------------------------------------------------

	typedef logic [1:0] counter_t;

	localparam counter_t counter_max        = 2'd3;
	localparam counter_t counter_weak_taken = 2'd2;

	typedef enum logic [1:0] {
		cls_call,
		cls_return,
		cls_absolute,
		cls_pc_relative
	} br_class_t;

	// Sizes used when the top level is not told otherwise
	localparam int default_btb_index_bits = 4;
	localparam int default_queue_depth    = 4;

endpackage : bp_pkg

// ==== hw/bp_predictor.sv ====
`timescale 1ns/10ps

module bp_predictor
	import bp_pkg::*;
#(
	parameter int BTB_INDEX_BITS = default_btb_index_bits
) (
	input  logic       clk,
	input  logic       reset_i,
	input  addr_t      fetch_pc_i,
	input  logic       upd_valid_i,
	input  word_addr_t upd_pc_i,
	input  logic       upd_taken_i,
	input  addr_t      upd_target_i,
	input  br_class_t  upd_class_i,
	input  addr_t      upd_link_i,
	output logic       pred_taken_o,
	output addr_t      pred_npc_o
);

	localparam int btb_entries = 1 << BTB_INDEX_BITS;
	localparam int word_bits   = $bits(word_addr_t);
	localparam int tag_bits    = word_bits - BTB_INDEX_BITS;

	typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
	typedef logic [tag_bits-1:0]       btb_tag_t;

	logic [btb_entries-1:0] btb_valid;
	btb_tag_t               btb_tag     [btb_entries];
	word_addr_t             btb_target  [btb_entries];
	br_class_t              btb_class   [btb_entries];
	counter_t               btb_counter [btb_entries];

	addr_t ret_addr;

	// ------------------------------------------------------------------------
	// Lookup
	// ------------------------------------------------------------------------

	word_addr_t fetch_word;
	btb_index_t fetch_index;
	btb_tag_t   fetch_tag;
	logic       fetch_hit;

	assign fetch_word  = fetch_pc_i[addr_width-1:2];
	assign fetch_index = fetch_word[BTB_INDEX_BITS-1:0];
	assign fetch_tag   = fetch_word[word_bits-1:BTB_INDEX_BITS];
	assign fetch_hit   = btb_valid[fetch_index] && (btb_tag[fetch_index] == fetch_tag);

	assign pred_taken_o = fetch_hit && (btb_counter[fetch_index] >= counter_weak_taken);

	always_comb begin : proc_pred_npc
		if (!pred_taken_o) begin
			pred_npc_o = fetch_pc_i + addr_t'(4);
		end else if (btb_class[fetch_index] == cls_return) begin
			pred_npc_o = ret_addr;
		end else begin
			pred_npc_o = {btb_target[fetch_index], 2'b00};
		end
	end

	// ------------------------------------------------------------------------
	// Update from execute
	// ------------------------------------------------------------------------

	btb_index_t upd_index;
	btb_tag_t   upd_tag;
	logic       upd_hit;
	counter_t   upd_counter_cur;
	counter_t   upd_counter_next;

	assign upd_index       = upd_pc_i[BTB_INDEX_BITS-1:0];
	assign upd_tag         = upd_pc_i[word_bits-1:BTB_INDEX_BITS];
	assign upd_hit         = btb_valid[upd_index] && (btb_tag[upd_index] == upd_tag);
	assign upd_counter_cur = btb_counter[upd_index];

	// Saturating counter step, fresh entries start weakly taken
	always_comb begin : proc_counter_next
		upd_counter_next = upd_counter_cur;
		if (upd_taken_i) begin
			if (!upd_hit) begin
				upd_counter_next = counter_weak_taken;
			end else if (upd_counter_cur != counter_max) begin
				upd_counter_next = upd_counter_cur + counter_t'(1);
			end
		end else if (upd_counter_cur != '0) begin
			upd_counter_next = upd_counter_cur - counter_t'(1);
		end
	end

	always_ff @(posedge clk) begin : proc_valid_ret
		if (reset_i) begin
			btb_valid <= '0;
			ret_addr  <= '0;
		end else if (upd_valid_i) begin
			if (upd_taken_i) begin
				btb_valid[upd_index] <= 1'b1;
			end
			if (upd_class_i == cls_call) begin
				ret_addr <= upd_link_i;
			end
		end
	end

	always_ff @(posedge clk) begin : proc_btb_entry
		if (upd_valid_i && (upd_taken_i || upd_hit)) begin
			btb_counter[upd_index] <= upd_counter_next;
		end
		if (upd_valid_i && upd_taken_i) begin
			btb_tag[upd_index]    <= upd_tag;
			btb_target[upd_index] <= upd_target_i[addr_width-1:2];
			btb_class[upd_index]  <= upd_class_i;
		end
	end

endmodule : bp_predictor

// ==== hw/bp_queue.sv ====
`timescale 1ns/10ps

module bp_queue
	import bp_pkg::*;
#(
	parameter int QUEUE_DEPTH = default_queue_depth
) (
	input  logic  clk,
	input  logic  reset_i,
	input  logic  push_i,
	input  logic  pop_i,
	input  logic  clear_i,
	input  addr_t push_pc_i,
	input  logic  push_taken_i,
	input  addr_t push_npc_i,
	output addr_t head_pc_o,
	output logic  head_taken_o,
	output addr_t head_npc_o,
	output logic  full_o
);

	localparam int ptr_bits = $clog2(QUEUE_DEPTH);

	typedef logic [ptr_bits-1:0] ptr_t;
	typedef logic [ptr_bits:0]   count_t;

	addr_t  entry_pc    [QUEUE_DEPTH];
	logic   entry_taken [QUEUE_DEPTH];
	addr_t  entry_npc   [QUEUE_DEPTH];

	ptr_t   rd_ptr;
	ptr_t   wr_ptr;
	count_t count;
	logic   push_ok;
	logic   pop_ok;

	assign full_o  = (count == count_t'(QUEUE_DEPTH));
	assign push_ok = push_i && !full_o;
	assign pop_ok  = pop_i && (count != '0);

	// Head is read straight from storage
	assign head_pc_o    = entry_pc[rd_ptr];
	assign head_taken_o = entry_taken[rd_ptr];
	assign head_npc_o   = entry_npc[rd_ptr];

	always_ff @(posedge clk) begin : proc_ptrs
		if (reset_i || clear_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + ptr_t'(1);
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + ptr_t'(1);
			end
			// Occupancy holds when push and pop meet
			if (push_ok && !pop_ok) begin
				count <= count + count_t'(1);
			end else if (pop_ok && !push_ok) begin
				count <= count - count_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin : proc_store
		if (push_ok) begin
			entry_pc[wr_ptr]    <= push_pc_i;
			entry_taken[wr_ptr] <= push_taken_i;
			entry_npc[wr_ptr]   <= push_npc_i;
		end
	end

endmodule : bp_queue

// ==== hw/bp_resolve.sv ====
`timescale 1ns/10ps

module bp_resolve
	import isa_pkg::*;
	import bp_pkg::*;
(
	input  logic         ex_valid_i,
	input  logic         stall_i,
	input  logic         csr_flush_i,
	input  addr_t        csr_target_i,
	input  addr_t        pc_i,
	input  addr_t        pred_npc_i,
	input  addr_t        rj_i,
	input  addr_t        rd_i,
	input  logic         pred_taken_i,
	input  branch_kind_t branch_kind_i,
	input  cmp_kind_t    cmp_kind_i,
	input  logic         branch_link_i,
	input  inst_field_t  inst_i,
	output logic         flush_o,
	output addr_t        redirect_pc_o,
	output addr_t        link_pc_o,
	output br_class_t    br_class_o,
	output logic         pop_o,
	output logic         upd_valid_o,
	output word_addr_t   upd_pc_o,
	output logic         upd_taken_o,
	output addr_t        upd_target_o
);

	// ------------------------------------------------------------------------
	// Instruction fields
	// ------------------------------------------------------------------------

	logic [15:0] offs16;
	reg_index_t  rj_index;
	reg_index_t  rd_index;
	addr_t       offs16_ext;
	addr_t       offs26_ext;

	assign offs16   = inst_i[inst_offs16_lsb +: 16];
	assign rj_index = inst_i[inst_rj_lsb +: reg_index_width];
	assign rd_index = inst_i[inst_rd_lsb +: reg_index_width];

	// Word offsets, sign extended and scaled to bytes
	assign offs16_ext = {{14{offs16[15]}}, offs16, 2'b00};
	assign offs26_ext = {{4{inst_i[offs26_hi_width-1]}}, inst_i[offs26_hi_width-1:0],
		offs16, 2'b00};

	// ------------------------------------------------------------------------
	// Direction and target
	// ------------------------------------------------------------------------

	logic  taken;
	addr_t target;

	always_comb begin : proc_taken
		if (branch_kind_i == branch_condition) begin
			case (cmp_kind_i)
				cmp_eql: taken = (rj_i == rd_i);
				cmp_neq: taken = (rj_i != rd_i);
				cmp_lss: taken = ($signed(rj_i) <  $signed(rd_i));
				cmp_ger: taken = ($signed(rj_i) >  $signed(rd_i));
				cmp_leq: taken = ($signed(rj_i) <= $signed(rd_i));
				cmp_geq: taken = ($signed(rj_i) >= $signed(rd_i));
				cmp_ltu: taken = (rj_i <  rd_i);
				cmp_geu: taken = (rj_i >= rd_i);
				default: taken = 1'b0;
			endcase
		end else begin
			taken = (branch_kind_i != branch_none);
		end
	end

	always_comb begin : proc_target
		if (branch_kind_i == branch_immediate) begin
			target = pc_i + offs26_ext;
		end else if (branch_kind_i == branch_indirect) begin
			target = rj_i + offs16_ext;
		end else if (branch_kind_i == branch_condition && taken) begin
			target = pc_i + offs16_ext;
		end else begin
			target = link_pc_o;
		end
	end

	assign link_pc_o = pc_i + addr_t'(4);

	// ------------------------------------------------------------------------
	// Mispredict and redirect
	// ------------------------------------------------------------------------

	logic dir_miss;
	logic target_miss;
	logic mispredict;

	assign dir_miss    = (pred_taken_i != taken);
	assign target_miss = pred_taken_i && (pred_npc_i != target);
	assign mispredict  = dir_miss || target_miss;

	assign pop_o         = ex_valid_i && !stall_i;
	assign flush_o       = (pop_o && mispredict) || csr_flush_i;
	assign redirect_pc_o = csr_flush_i ? csr_target_i : target;

	// Call, return, absolute or pc-relative
	always_comb begin : proc_class
		if ((branch_kind_i == branch_indirect && rd_index == link_reg_index) || branch_link_i) begin
			br_class_o = cls_call;
		end else if (branch_kind_i == branch_indirect && rj_index == link_reg_index
				&& offs16 == '0) begin
			br_class_o = cls_return;
		end else if (branch_kind_i == branch_immediate || branch_kind_i == branch_indirect) begin
			br_class_o = cls_absolute;
		end else begin
			br_class_o = cls_pc_relative;
		end
	end

	// Predictor training on every retired branch
	assign upd_valid_o  = pop_o && (branch_kind_i != branch_none);
	assign upd_pc_o     = pc_i[addr_width-1:2];
	assign upd_taken_o  = taken;
	assign upd_target_o = target;

endmodule : bp_resolve

// ==== hw/bp_top.sv ====
`timescale 1ns/10ps

module bp_top
	import isa_pkg::*;
	import bp_pkg::*;
#(
	parameter int BTB_INDEX_BITS = default_btb_index_bits,
	parameter int QUEUE_DEPTH    = default_queue_depth
) (
	input  logic         clk,
	input  logic         reset_i,
	// Fetch side
	input  logic         fetch_valid_i,
	input  addr_t        fetch_pc_i,
	output addr_t        fetch_npc_o,
	output logic         queue_full_o,
	// Execute side
	input  logic         ex_valid_i,
	input  branch_kind_t ex_branch_kind_i,
	input  cmp_kind_t    ex_cmp_kind_i,
	input  logic         ex_branch_link_i,
	input  inst_field_t  ex_inst_i,
	input  addr_t        ex_rj_i,
	input  addr_t        ex_rd_i,
	input  logic         stall_i,
	input  logic         csr_flush_i,
	input  addr_t        csr_target_i,
	output logic         flush_o,
	output addr_t        redirect_pc_o,
	output addr_t        link_pc_o,
	output br_class_t    br_class_o
);

	logic       pred_taken;
	addr_t      head_pc;
	logic       head_taken;
	addr_t      head_npc;
	logic       pop;
	logic       upd_valid;
	word_addr_t upd_pc;
	logic       upd_taken;
	addr_t      upd_target;

	bp_predictor #(
		.BTB_INDEX_BITS(BTB_INDEX_BITS)
	) u_predictor (
		.clk         (clk),
		.reset_i     (reset_i),
		.fetch_pc_i  (fetch_pc_i),
		.upd_valid_i (upd_valid),
		.upd_pc_i    (upd_pc),
		.upd_taken_i (upd_taken),
		.upd_target_i(upd_target),
		.upd_class_i (br_class_o),
		.upd_link_i  (link_pc_o),
		.pred_taken_o(pred_taken),
		.pred_npc_o  (fetch_npc_o)
	);

	// Any flush drops all younger predictions
	bp_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clk         (clk),
		.reset_i     (reset_i),
		.push_i      (fetch_valid_i),
		.pop_i       (pop),
		.clear_i     (flush_o),
		.push_pc_i   (fetch_pc_i),
		.push_taken_i(pred_taken),
		.push_npc_i  (fetch_npc_o),
		.head_pc_o   (head_pc),
		.head_taken_o(head_taken),
		.head_npc_o  (head_npc),
		.full_o      (queue_full_o)
	);

	bp_resolve u_resolve (
		.ex_valid_i   (ex_valid_i),
		.stall_i      (stall_i),
		.csr_flush_i  (csr_flush_i),
		.csr_target_i (csr_target_i),
		.pc_i         (head_pc),
		.pred_npc_i   (head_npc),
		.rj_i         (ex_rj_i),
		.rd_i         (ex_rd_i),
		.pred_taken_i (head_taken),
		.branch_kind_i(ex_branch_kind_i),
		.cmp_kind_i   (ex_cmp_kind_i),
		.branch_link_i(ex_branch_link_i),
		.inst_i       (ex_inst_i),
		.flush_o      (flush_o),
		.redirect_pc_o(redirect_pc_o),
		.link_pc_o    (link_pc_o),
		.br_class_o   (br_class_o),
		.pop_o        (pop),
		.upd_valid_o  (upd_valid),
		.upd_pc_o     (upd_pc),
		.upd_taken_o  (upd_taken),
		.upd_target_o (upd_target)
	);

endmodule : bp_top

// ==== test/tb_bp_top.sv ====
`timescale 1ns/10ps

module tb_bp_top
	import isa_pkg::*;
	import bp_pkg::*;
();

	localparam int depth    = default_queue_depth;
	localparam int btb_size = 1 << default_btb_index_bits;

	logic         clk = 1'b0;
	logic         reset_i;
	logic         fetch_valid_i;
	addr_t        fetch_pc_i;
	addr_t        fetch_npc_o;
	logic         queue_full_o;
	logic         ex_valid_i;
	branch_kind_t ex_branch_kind_i;
	cmp_kind_t    ex_cmp_kind_i;
	logic         ex_branch_link_i;
	inst_field_t  ex_inst_i;
	addr_t        ex_rj_i;
	addr_t        ex_rd_i;
	logic         stall_i;
	logic         csr_flush_i;
	addr_t        csr_target_i;
	logic         flush_o;
	addr_t        redirect_pc_o;
	addr_t        link_pc_o;
	br_class_t    br_class_o;

	bp_top #(
		.BTB_INDEX_BITS(default_btb_index_bits),
		.QUEUE_DEPTH   (default_queue_depth)
	) uut (
		.clk             (clk),
		.reset_i         (reset_i),
		.fetch_valid_i   (fetch_valid_i),
		.fetch_pc_i      (fetch_pc_i),
		.fetch_npc_o     (fetch_npc_o),
		.queue_full_o    (queue_full_o),
		.ex_valid_i      (ex_valid_i),
		.ex_branch_kind_i(ex_branch_kind_i),
		.ex_cmp_kind_i   (ex_cmp_kind_i),
		.ex_branch_link_i(ex_branch_link_i),
		.ex_inst_i       (ex_inst_i),
		.ex_rj_i         (ex_rj_i),
		.ex_rd_i         (ex_rd_i),
		.stall_i         (stall_i),
		.csr_flush_i     (csr_flush_i),
		.csr_target_i    (csr_target_i),
		.flush_o         (flush_o),
		.redirect_pc_o   (redirect_pc_o),
		.link_pc_o       (link_pc_o),
		.br_class_o      (br_class_o)
	);

	always #50 clk = ~clk;

	// ------------------------------------------------------------------------
	// Reference state of the BTB, return register and in-flight fetches
	// ------------------------------------------------------------------------

	logic       m_valid  [btb_size];
	word_addr_t m_tag    [btb_size];
	addr_t      m_target [btb_size];
	br_class_t  m_class  [btb_size];
	counter_t   m_ctr    [btb_size];
	addr_t      m_ret;

	addr_t q_pc[$];
	logic  q_taken[$];
	addr_t q_npc[$];

	logic [31:0] lfsr_state;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			value = {value[30:0], lfsr_state[0]};
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
		end
		return value;
	endfunction

	function automatic inst_field_t inst16(input logic [15:0] off, input reg_index_t rj,
			input reg_index_t rd);
		return {off, rj, rd};
	endfunction

	// 26-bit offset with its low 16 bits on top
	function automatic inst_field_t inst26(input logic [25:0] off);
		return {off[15:0], off[25:16]};
	endfunction

	function automatic int btb_slot(input addr_t pc);
		return int'(pc[2 +: default_btb_index_bits]);
	endfunction

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
				$time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic model_predict(input addr_t pc, output logic taken, output addr_t npc);
		int   i;
		logic hit;
		i     = btb_slot(pc);
		hit   = m_valid[i] && (m_tag[i] == pc[31:2]);
		taken = hit && (m_ctr[i] >= 2'd2);
		if (!taken) begin
			npc = pc + 32'd4;
		end else if (m_class[i] == cls_return) begin
			npc = m_ret;
		end else begin
			npc = m_target[i];
		end
	endtask

	task automatic model_update(input addr_t pc, input logic taken, input addr_t target,
			input br_class_t cls);
		int   i;
		logic hit;
		i   = btb_slot(pc);
		hit = m_valid[i] && (m_tag[i] == pc[31:2]);
		if (taken) begin
			m_ctr[i]    = !hit ? 2'd2 : ((m_ctr[i] == 2'd3) ? 2'd3 : m_ctr[i] + 2'd1);
			m_valid[i]  = 1'b1;
			m_tag[i]    = pc[31:2];
			m_target[i] = {target[31:2], 2'b00};
			m_class[i]  = cls;
		end else if (hit && m_ctr[i] != 2'd0) begin
			m_ctr[i] = m_ctr[i] - 2'd1;
		end
		if (cls == cls_call) begin
			m_ret = pc + 32'd4;
		end
	endtask

	// Taken, target and class of a resolved instruction
	task automatic apply_rules(input addr_t pc, input branch_kind_t kind, input cmp_kind_t cmp,
			input logic link, input inst_field_t inst, input addr_t rj, input addr_t rd,
			output logic taken, output addr_t target, output br_class_t cls);
		logic [15:0] off16;
		logic [25:0] off26;
		reg_index_t  rj_idx;
		reg_index_t  rd_idx;
		addr_t       ext16;
		addr_t       ext26;
		off16  = inst[25:10];
		off26  = {inst[9:0], inst[25:10]};
		rj_idx = inst[9:5];
		rd_idx = inst[4:0];
		ext16  = {{14{off16[15]}}, off16, 2'b00};
		ext26  = {{4{off26[25]}}, off26, 2'b00};
		case (kind)
			branch_condition: begin
				case (cmp)
					cmp_eql: taken = (rj == rd);
					cmp_neq: taken = (rj != rd);
					cmp_lss: taken = ($signed(rj) < $signed(rd));
					cmp_ger: taken = ($signed(rj) > $signed(rd));
					cmp_leq: taken = ($signed(rj) <= $signed(rd));
					cmp_geq: taken = ($signed(rj) >= $signed(rd));
					cmp_ltu: taken = (rj < rd);
					default: taken = (rj >= rd);
				endcase
			end
			branch_immediate, branch_indirect: taken = 1'b1;
			default: taken = 1'b0;
		endcase
		if (kind == branch_immediate) begin
			target = pc + ext26;
		end else if (kind == branch_indirect) begin
			target = rj + ext16;
		end else if (kind == branch_condition && taken) begin
			target = pc + ext16;
		end else begin
			target = pc + 32'd4;
		end
		if ((kind == branch_indirect && rd_idx == 5'd1) || link) begin
			cls = cls_call;
		end else if (kind == branch_indirect && rj_idx == 5'd1 && off16 == 16'd0) begin
			cls = cls_return;
		end else if (kind == branch_immediate || kind == branch_indirect) begin
			cls = cls_absolute;
		end else begin
			cls = cls_pc_relative;
		end
	endtask

	// ------------------------------------------------------------------------
	// Cycle steps driven on the rising edge and checked on the falling one
	// ------------------------------------------------------------------------

	task automatic check_quiet();
		check_value("queue_full_o", 32'(queue_full_o), 32'(q_pc.size() == depth));
		check_value("flush_o", 32'(flush_o), 32'd0);
	endtask

	task automatic idle_step();
		@(posedge clk);
		fetch_valid_i <= 1'b0;
		ex_valid_i    <= 1'b0;
		stall_i       <= 1'b0;
		csr_flush_i   <= 1'b0;
		@(negedge clk);
		check_quiet();
	endtask

	task automatic fetch_step(input addr_t pc);
		logic  p_taken;
		addr_t p_npc;
		@(posedge clk);
		fetch_valid_i <= 1'b1;
		fetch_pc_i    <= pc;
		ex_valid_i    <= 1'b0;
		stall_i       <= 1'b0;
		csr_flush_i   <= 1'b0;
		@(negedge clk);
		check_quiet();
		model_predict(pc, p_taken, p_npc);
		check_value("fetch_npc_o", fetch_npc_o, p_npc);
		q_pc.push_back(pc);
		q_taken.push_back(p_taken);
		q_npc.push_back(p_npc);
	endtask

	task automatic resolve_step(input branch_kind_t kind, input cmp_kind_t cmp,
			input logic link, input inst_field_t inst, input addr_t rj, input addr_t rd,
			input logic stall, input logic csr, input addr_t csr_pc);
		addr_t     pc;
		logic      taken;
		addr_t     target;
		br_class_t cls;
		logic      miss;
		logic      exp_flush;
		@(posedge clk);
		fetch_valid_i    <= 1'b0;
		ex_valid_i       <= 1'b1;
		ex_branch_kind_i <= kind;
		ex_cmp_kind_i    <= cmp;
		ex_branch_link_i <= link;
		ex_inst_i        <= inst;
		ex_rj_i          <= rj;
		ex_rd_i          <= rd;
		stall_i          <= stall;
		csr_flush_i      <= csr;
		csr_target_i     <= csr_pc;
		@(negedge clk);
		check_value("queue_full_o", 32'(queue_full_o), 32'(q_pc.size() == depth));
		if (q_pc.size() == 0) begin
			$display("Resolve issued with no fetch in flight");
			abort_run();
		end
		pc = q_pc[0];
		apply_rules(pc, kind, cmp, link, inst, rj, rd, taken, target, cls);
		miss      = (q_taken[0] != taken) || (q_taken[0] && q_npc[0] != target);
		exp_flush = csr || (!stall && miss);
		check_value("flush_o", 32'(flush_o), 32'(exp_flush));
		check_value("redirect_pc_o", redirect_pc_o, csr ? csr_pc : target);
		check_value("link_pc_o", link_pc_o, pc + 32'd4);
		check_value("br_class_o", 32'(br_class_o), 32'(cls));
		if (!stall) begin
			void'(q_pc.pop_front());
			void'(q_taken.pop_front());
			void'(q_npc.pop_front());
			if (kind != branch_none) begin
				model_update(pc, taken, target, cls);
			end
		end
		if (exp_flush) begin
			q_pc.delete();
			q_taken.delete();
			q_npc.delete();
		end
	endtask

	task automatic wait_for_full(input int limit);
		int n;
		n = 0;
		while (!queue_full_o) begin
			if (n == limit) begin
				$display("Timeout while waiting for queue_full_o to rise");
				abort_run();
			end
			idle_step();
			n++;
		end
	endtask

	// Stalls never flush and a CSR flush always wins
	assert property (@(negedge clk) (stall_i && !csr_flush_i) |-> !flush_o)
	else begin
		$display("** Error at %0t ns: flush_o = 1 during a stall, expected 0", $time);
		abort_run();
	end

	assert property (@(negedge clk) csr_flush_i |-> flush_o)
	else begin
		$display("** Error at %0t ns: flush_o = 0 on CSR flush, expected 1", $time);
		abort_run();
	end

	assert property (@(negedge clk) csr_flush_i |-> (redirect_pc_o == csr_target_i))
	else begin
		$display("** Error at %0t ns: redirect_pc_o = 0x%08h, expected 0x%08h on CSR flush",
			$time, redirect_pc_o, csr_target_i);
		abort_run();
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin : proc_main
		addr_t       pc;
		addr_t       opa;
		addr_t       opb;
		logic [25:0] off26;
		lfsr_state = 32'd86;
		for (int i = 0; i < btb_size; i++) begin
			m_valid[i] = 1'b0;
			m_ctr[i]   = 2'd0;
		end
		m_ret = '0;
		reset_i          <= 1'b1;
		fetch_valid_i    <= 1'b0;
		fetch_pc_i       <= '0;
		ex_valid_i       <= 1'b0;
		ex_branch_kind_i <= branch_none;
		ex_cmp_kind_i    <= cmp_eql;
		ex_branch_link_i <= 1'b0;
		ex_inst_i        <= '0;
		ex_rj_i          <= '0;
		ex_rd_i          <= '0;
		stall_i          <= 1'b0;
		csr_flush_i      <= 1'b0;
		csr_target_i     <= '0;
		repeat (2) @(posedge clk);
		reset_i <= 1'b0;
		idle_step();

		// All compare kinds on edge and random operands
		for (int k = 0; k < 8; k++) begin
			for (int v = 0; v < 6; v++) begin
				case (v)
					0: begin
						opa = rand_bits(32);
						opb = opa;
					end
					1: begin
						opa = 32'h8000_0000;
						opb = 32'h0000_0001;
					end
					2: begin
						opa = 32'h0000_0001;
						opb = 32'h8000_0000;
					end
					3: begin
						opa = 32'hFFFF_FFFF;
						opb = 32'h0000_0000;
					end
					default: begin
						opa = rand_bits(32);
						opb = rand_bits(32);
					end
				endcase
				pc = 32'h0001_0000 + addr_t'((k * 6 + v) * 4);
				fetch_step(pc);
				resolve_step(branch_condition, cmp_kind_t'(k), 1'b0,
					inst16(16'(rand_bits(16)), 5'd4, 5'd5), opa, opb, 1'b0, 1'b0, '0);
			end
		end

		// Training of one immediate branch
		pc    = 32'h0000_2040;
		off26 = 26'(rand_bits(26));
		fetch_step(pc);
		resolve_step(branch_immediate, cmp_eql, 1'b0, inst26(off26), '0, '0, 1'b0, 1'b0, '0);
		fetch_step(pc);
		check_value("fetch_npc_o", fetch_npc_o, pc + {{4{off26[25]}}, off26, 2'b00});
		resolve_step(branch_immediate, cmp_eql, 1'b0, inst26(off26), '0, '0, 1'b0, 1'b0, '0);
		for (int n = 0; n < 2; n++) begin
			fetch_step(pc);
			resolve_step(branch_condition, cmp_eql, 1'b0, inst16(16'h0010, 5'd4, 5'd5),
				32'd1, 32'd2, 1'b0, 1'b0, '0);
		end
		fetch_step(pc);
		check_value("fetch_npc_o", fetch_npc_o, pc + 32'd4);
		resolve_step(branch_none, cmp_eql, 1'b0, '0, '0, '0, 1'b0, 1'b0, '0);

		// Calls load the return register and returns use it
		fetch_step(32'h0000_3000);
		resolve_step(branch_indirect, cmp_eql, 1'b0, inst16(16'h0011, 5'd4, 5'd1),
			32'h0000_8000, '0, 1'b0, 1'b0, '0);
		fetch_step(32'h0000_8044);
		resolve_step(branch_indirect, cmp_eql, 1'b0, inst16(16'h0000, 5'd1, 5'd0),
			32'h0000_3004, '0, 1'b0, 1'b0, '0);
		fetch_step(32'h0000_5008);
		resolve_step(branch_immediate, cmp_eql, 1'b1, inst26(26'h000_0100), '0, '0,
			1'b0, 1'b0, '0);
		fetch_step(32'h0000_8044);
		check_value("fetch_npc_o", fetch_npc_o, 32'h0000_500C);
		resolve_step(branch_indirect, cmp_eql, 1'b0, inst16(16'h0000, 5'd1, 5'd0),
			32'h0000_500C, '0, 1'b0, 1'b0, '0);

		// Stalled mispredict before the same entry resolves
		fetch_step(32'h0000_6010);
		resolve_step(branch_condition, cmp_neq, 1'b0, inst16(16'h0040, 5'd4, 5'd5),
			32'd1, 32'd2, 1'b1, 1'b0, '0);
		resolve_step(branch_condition, cmp_neq, 1'b0, inst16(16'h0040, 5'd4, 5'd5),
			32'd1, 32'd2, 1'b0, 1'b0, '0);
		fetch_step(32'h0000_7000);
		fetch_step(32'h0000_7004);
		resolve_step(branch_none, cmp_eql, 1'b0, '0, '0, '0, 1'b0, 1'b1, 32'h0000_0800);
		fetch_step(32'h0000_0800);
		resolve_step(branch_none, cmp_eql, 1'b0, '0, '0, '0, 1'b0, 1'b0, '0);

		// Fill the queue and drain it in order
		for (int n = 0; n < depth; n++) begin
			fetch_step(32'h0000_9000 + addr_t'(n * 4));
		end
		wait_for_full(4);
		for (int n = 0; n < depth; n++) begin
			resolve_step(branch_none, cmp_eql, 1'b0, '0, '0, '0, 1'b0, 1'b0, '0);
		end
		idle_step();

		$display("TB PASSED");
		$finish;
	end

endmodule : tb_bp_top

// ==== src.f ====
hw/isa_pkg.sv
hw/bp_pkg.sv
hw/bp_predictor.sv
hw/bp_queue.sv
hw/bp_resolve.sv
hw/bp_top.sv
test/tb_bp_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_bp_top \
	-f src.f -o sim_tb_bp_top \
	&& ./obj_dir/sim_tb_bp_top | tee /dev/stderr | grep "TB PASSED" > /dev/null \
	&& echo "Simulation result: pass" \
	|| { echo "Simulation result: fail"; exit 1; }
